// File: build.f
logic/pcie_rx_pkg.sv
logic/rx_tlp_decoder.sv
logic/cpld_ram_writer.sv
logic/pcie_rx.sv
test/pcie_rx_assert.sv
test/pcie_rx_tb.sv

// File: logic/cpld_ram_writer.sv
`timescale 1ns/1ps

module cpld_ram_writer
    import pcie_rx_pkg::*;
#(
    parameter int RAM_ADDR_W = 11
) (
    input  logic                  user_clk,
    input  logic                  user_reset,

    input  cpld_beat_t            cpld_i,
    input  logic [RAM_ADDR_W-1:0] dma_byte_len_i,

    output ram_wr_t               ram_wr_o,
    output logic                  ram_tx_start_o,
    output logic                  ram_tx_end_o
);

    logic [RAM_ADDR_W-1:0] dma_dw_len;
    logic [RAM_ADDR_W-1:0] dw_total;
    logic [RAM_ADDR_W-1:0] ram_addr;
    logic [31:0]           ram_data;
    logic                  ram_we;
    logic                  judge;
    logic                  dma_end;
    logic                  in_xfer;
    logic [1:0]            start_sr;
    logic [1:0]            end_sr;

    // bytes rounded up to whole dwords
    assign dma_dw_len = {2'b00, dma_byte_len_i[RAM_ADDR_W-1:2]}
                      + {{(RAM_ADDR_W-1){1'b0}}, |dma_byte_len_i[1:0]};

    assign dma_end = judge & (dw_total >= dma_dw_len);

    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            ram_we <= 1'b0;
            judge  <= 1'b0;
        end else begin
            ram_we <= cpld_i.valid;
            judge  <= cpld_i.valid & cpld_i.last;
        end
    end

    always_ff @(posedge user_clk) begin
        if (cpld_i.valid) begin
            ram_data <= byte_swap(cpld_i.data);
        end
    end

    // running total across completions of one transfer
    always_ff @(posedge user_clk) begin
        if (user_reset || dma_end) begin
            dw_total <= '0;
            in_xfer  <= 1'b0;
        end else if (cpld_i.valid) begin
            dw_total <= dw_total + 1'b1;
            in_xfer  <= 1'b1;
        end
    end

    always_ff @(posedge user_clk) begin
        if (user_reset || dma_end) begin
            ram_addr <= '0;
        end else if (ram_we) begin
            ram_addr <= ram_addr + 1'b1;
        end
    end

    // framing pulses are stretched to two cycles
    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            start_sr <= '0;
            end_sr   <= '0;
        end else begin
            start_sr <= {start_sr[0], cpld_i.valid & ~in_xfer};
            end_sr   <= {end_sr[0], dma_end};
        end
    end

    assign ram_tx_start_o = |start_sr;
    assign ram_tx_end_o   = |end_sr;

    assign ram_wr_o = '{
        we:   ram_we,
        addr: RAM_ADDR_FIELD_W'(ram_addr),
        data: ram_data
    };

endmodule

// File: logic/pcie_rx.sv
`timescale 1ns/1ps

module pcie_rx
    import pcie_rx_pkg::*;
#(
    parameter int BAR_ADDR_W = 16,
    parameter int RAM_ADDR_W = 11
) (
    input  logic                  user_clk,
    input  logic                  user_reset,

    input  logic [31:0]           m_axis_rx_tdata_i,
    input  logic                  m_axis_rx_tvalid_i,
    output logic                  m_axis_rx_tready_o,

    input  logic                  compl_done_i,
    input  logic [RAM_ADDR_W-1:0] dma_byte_len_i,

    output bar_wr_t               bar_wr_o,
    output mem_req_t              req_o,
    output logic                  req_compld_o,

    output ram_wr_t               ram_wr_o,
    output logic                  ram_tx_start_o,
    output logic                  ram_tx_end_o
);

    cpld_beat_t cpld;

    rx_tlp_decoder #(
        .BAR_ADDR_W         (BAR_ADDR_W)
    ) u_rx_tlp_decoder (
        .user_clk           (user_clk),
        .user_reset         (user_reset),
        .m_axis_rx_tdata_i  (m_axis_rx_tdata_i),
        .m_axis_rx_tvalid_i (m_axis_rx_tvalid_i),
        .m_axis_rx_tready_o (m_axis_rx_tready_o),
        .compl_done_i       (compl_done_i),
        .bar_wr_o           (bar_wr_o),
        .req_o              (req_o),
        .req_compld_o       (req_compld_o),
        .cpld_o             (cpld)
    );

    // completion payload into the dma buffer
    cpld_ram_writer #(
        .RAM_ADDR_W     (RAM_ADDR_W)
    ) u_cpld_ram_writer (
        .user_clk       (user_clk),
        .user_reset     (user_reset),
        .cpld_i         (cpld),
        .dma_byte_len_i (dma_byte_len_i),
        .ram_wr_o       (ram_wr_o),
        .ram_tx_start_o (ram_tx_start_o),
        .ram_tx_end_o   (ram_tx_end_o)
    );

endmodule

// File: logic/pcie_rx_pkg.sv
package pcie_rx_pkg;

    // widest address fields the output records can carry
    localparam int BAR_ADDR_FIELD_W = 16;
    localparam int RAM_ADDR_FIELD_W = 11;

    // fmt[1:0] and type[4:0] of dw0
    typedef enum logic [6:0] {
        MEM_RD32 = 7'b00_00000,
        MEM_WR32 = 7'b10_00000,
        MEM_RD64 = 7'b01_00000,
        MEM_WR64 = 7'b11_00000,
        CPL      = 7'b00_01010,
        CPLD     = 7'b10_01010
    } tlp_fmt_type_e;

    typedef struct packed {
        logic       rsv0;
        logic [6:0] fmt_type;
        logic       rsv1;
        logic [2:0] tc;
        logic [3:0] rsv2;
        logic       td;
        logic       ep;
        logic [1:0] attr;
        logic [1:0] rsv3;
        logic [9:0] len;
    } tlp_dw0_t;

    typedef struct packed {
        logic [2:0]  tc;
        logic        td;
        logic        ep;
        logic [1:0]  attr;
        logic [9:0]  len;
        logic [15:0] rid;
        logic [7:0]  tag;
        logic [7:0]  be;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                        en;
        logic [7:0]                  be;
        logic [BAR_ADDR_FIELD_W-1:0] addr;
        logic [31:0]                 data;
    } bar_wr_t;

    typedef struct packed {
        logic                        we;
        logic [RAM_ADDR_FIELD_W-1:0] addr;
        logic [31:0]                 data;
    } ram_wr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        last;
    } cpld_beat_t;

    // tlp payload is big endian on the wire
    function automatic logic [31:0] byte_swap(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

endpackage

// File: logic/rx_tlp_decoder.sv
`timescale 1ns/1ps

module rx_tlp_decoder
    import pcie_rx_pkg::*;
#(
    parameter int BAR_ADDR_W = 16
) (
    input  logic        user_clk,
    input  logic        user_reset,

    input  logic [31:0] m_axis_rx_tdata_i,
    input  logic        m_axis_rx_tvalid_i,
    output logic        m_axis_rx_tready_o,

    input  logic        compl_done_i,

    output bar_wr_t     bar_wr_o,
    output mem_req_t    req_o,
    output logic        req_compld_o,
    output cpld_beat_t  cpld_o
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_MWR_DW1,
        ST_MWR_ADDR_HI,
        ST_MWR_ADDR_LO,
        ST_MWR_DATA,
        ST_MRD_DW1,
        ST_MRD_ADDR_HI,
        ST_MRD_ADDR_LO,
        ST_MRD_WAIT,
        ST_CPLD_DW1,
        ST_CPLD_DW2,
        ST_CPLD_DATA,
        ST_DMA_JUDGE
    } state_e;

    state_e                state;
    tlp_dw0_t              dw0;
    logic                  accept;
    logic                  is_mrd;
    logic                  is_64;
    logic [9:0]            tlp_len;
    logic [9:0]            dw_cnt;
    logic                  tlp_end;

    logic                  bar_en;
    logic [7:0]            bar_be;
    logic [BAR_ADDR_W-1:0] bar_addr;
    logic [31:0]           bar_data;

    logic                  cpld_valid;
    logic [31:0]           cpld_data;
    logic                  cpld_last;

    assign dw0     = tlp_dw0_t'(m_axis_rx_tdata_i);
    assign accept  = m_axis_rx_tvalid_i & m_axis_rx_tready_o;
    assign is_mrd  = (dw0.fmt_type == MEM_RD32) || (dw0.fmt_type == MEM_RD64);
    // len of 0 wraps to 1024 dwords
    assign tlp_end = (dw_cnt == tlp_len - 10'd1);

    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            state              <= ST_IDLE;
            m_axis_rx_tready_o <= 1'b0;
            bar_en             <= 1'b0;
            req_compld_o       <= 1'b0;
            cpld_valid         <= 1'b0;
        end else begin
            bar_en             <= 1'b0;
            req_compld_o       <= 1'b0;
            cpld_valid         <= 1'b0;
            m_axis_rx_tready_o <= 1'b1;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        case (dw0.fmt_type)
                            MEM_WR32, MEM_WR64: state <= ST_MWR_DW1;
                            MEM_RD32, MEM_RD64: state <= ST_MRD_DW1;
                            CPLD:               state <= ST_CPLD_DW1;
                            // cpl and anything unknown is dropped here
                            default:            state <= ST_IDLE;
                        endcase
                    end
                end
                ST_MWR_DW1: begin
                    if (accept) begin
                        state <= is_64 ? ST_MWR_ADDR_HI : ST_MWR_ADDR_LO;
                    end
                end
                ST_MWR_ADDR_HI: begin
                    if (accept) begin
                        state <= ST_MWR_ADDR_LO;
                    end
                end
                ST_MWR_ADDR_LO: begin
                    if (accept) begin
                        state <= ST_MWR_DATA;
                    end
                end
                ST_MWR_DATA: begin
                    if (accept) begin
                        bar_en <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                ST_MRD_DW1: begin
                    if (accept) begin
                        state <= is_64 ? ST_MRD_ADDR_HI : ST_MRD_ADDR_LO;
                    end
                end
                ST_MRD_ADDR_HI: begin
                    if (accept) begin
                        state <= ST_MRD_ADDR_LO;
                    end
                end
                ST_MRD_ADDR_LO: begin
                    if (accept) begin
                        req_compld_o       <= 1'b1;
                        m_axis_rx_tready_o <= 1'b0;
                        state              <= ST_MRD_WAIT;
                    end
                end
                ST_MRD_WAIT: begin
                    // stall input until the completer is done
                    m_axis_rx_tready_o <= compl_done_i;
                    if (compl_done_i) begin
                        state <= ST_IDLE;
                    end
                end
                ST_CPLD_DW1: begin
                    if (accept) begin
                        state <= ST_CPLD_DW2;
                    end
                end
                ST_CPLD_DW2: begin
                    if (accept) begin
                        state <= ST_CPLD_DATA;
                    end
                end
                ST_CPLD_DATA: begin
                    if (accept) begin
                        cpld_valid <= 1'b1;
                        if (tlp_end) begin
                            m_axis_rx_tready_o <= 1'b0;
                            state              <= ST_DMA_JUDGE;
                        end
                    end
                end
                // one idle beat while the writer checks the dma length
                ST_DMA_JUDGE: state <= ST_IDLE;
                default:      state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge user_clk) begin
        if (accept) begin
            case (state)
                ST_IDLE: begin
                    is_64   <= dw0.fmt_type[5];
                    tlp_len <= dw0.len;
                    if (is_mrd) begin
                        req_o.tc   <= dw0.tc;
                        req_o.td   <= dw0.td;
                        req_o.ep   <= dw0.ep;
                        req_o.attr <= dw0.attr;
                        req_o.len  <= dw0.len;
                    end
                end
                ST_MWR_DW1:     bar_be   <= m_axis_rx_tdata_i[7:0];
                ST_MWR_ADDR_LO: bar_addr <= {m_axis_rx_tdata_i[BAR_ADDR_W-1:2], 2'b00};
                ST_MWR_DATA:    bar_data <= byte_swap(m_axis_rx_tdata_i);
                ST_MRD_DW1: begin
                    req_o.rid <= m_axis_rx_tdata_i[31:16];
                    req_o.tag <= m_axis_rx_tdata_i[15:8];
                    req_o.be  <= m_axis_rx_tdata_i[7:0];
                end
                ST_MRD_ADDR_LO: req_o.addr <= m_axis_rx_tdata_i;
                ST_CPLD_DW2:    dw_cnt     <= '0;
                ST_CPLD_DATA: begin
                    cpld_data <= m_axis_rx_tdata_i;
                    cpld_last <= tlp_end;
                    dw_cnt    <= dw_cnt + 10'd1;
                end
                default: ;
            endcase
        end
    end

    assign bar_wr_o = '{
        en:   bar_en,
        be:   bar_be,
        addr: BAR_ADDR_FIELD_W'(bar_addr),
        data: bar_data
    };

    assign cpld_o = '{valid: cpld_valid, data: cpld_data, last: cpld_last};

endmodule

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module pcie_rx_tb -o pcie_rx_sim &&
./obj_dir/pcie_rx_sim || exit 1

// File: test/pcie_rx_assert.sv
`timescale 1ns/1ps

module pcie_rx_assert (
    input logic user_clk,
    input logic user_reset,
    input logic bar_en_i,
    input logic req_compld_i,
    input logic tready_i,
    input logic rd_wait_i,
    input logic ram_tx_start_i
);

    // strobes last a single cycle
    bar_en_single: assert property (@(posedge user_clk) disable iff (user_reset)
        bar_en_i |=> !bar_en_i)
        else $error("bar write strobe held for two cycles");

    req_compld_single: assert property (@(posedge user_clk) disable iff (user_reset)
        req_compld_i |=> !req_compld_i)
        else $error("completion request held for two cycles");

    // input stalls while a read is outstanding
    read_stall: assert property (@(posedge user_clk) disable iff (user_reset)
        rd_wait_i |-> !tready_i)
        else $error("tready high while a read waits for completion");

    start_min_two: assert property (@(posedge user_clk) disable iff (user_reset)
        $rose(ram_tx_start_i) |=> ram_tx_start_i)
        else $error("ram start pulse shorter than two cycles");

    start_max_two: assert property (@(posedge user_clk) disable iff (user_reset)
        ram_tx_start_i && $past(ram_tx_start_i) |=> !ram_tx_start_i)
        else $error("ram start pulse longer than two cycles");

endmodule

bind rx_tlp_decoder pcie_rx_assert u_dec_assert (
    .user_clk       (user_clk),
    .user_reset     (user_reset),
    .bar_en_i       (bar_en),
    .req_compld_i   (req_compld_o),
    .tready_i       (m_axis_rx_tready_o),
    .rd_wait_i      (state == ST_MRD_WAIT),
    .ram_tx_start_i (1'b0)
);

bind cpld_ram_writer pcie_rx_assert u_wr_assert (
    .user_clk       (user_clk),
    .user_reset     (user_reset),
    .bar_en_i       (1'b0),
    .req_compld_i   (1'b0),
    .tready_i       (1'b0),
    .rd_wait_i      (1'b0),
    .ram_tx_start_i (ram_tx_start_o)
);

// File: test/pcie_rx_tb.sv
`timescale 1ns/1ps

module pcie_rx_tb
    import pcie_rx_pkg::*;
();

    localparam int BAR_ADDR_W     = 16;
    localparam int RAM_ADDR_W     = 11;
    localparam int CLK_PERIOD     = 40;
    localparam int N_TESTS        = 5;
    localparam int BEATS_PER_TEST = 32;

    logic                  user_clk;
    logic                  user_reset;
    logic [31:0]           rx_tdata;
    logic                  rx_tvalid;
    logic                  rx_tready;
    logic                  compl_done;
    logic [RAM_ADDR_W-1:0] dma_byte_len;
    bar_wr_t               bar_wr;
    mem_req_t              req;
    logic                  req_compld;
    ram_wr_t               ram_wr;
    logic                  ram_tx_start;
    logic                  ram_tx_end;

    // expected results, filled before each TLP goes out
    bar_wr_t     exp_bar_q[$];
    mem_req_t    exp_req_q[$];
    ram_wr_t     exp_ram_q[$];
    logic        exp_first_q[$];
    logic        exp_last_q[$];
    int          ref_ram_addr;
    int          ref_dw_total;
    logic [31:0] tlp[$];
    integer      seed;
    logic        start_prev = 1'b0;
    logic [1:0]  end_hist = 2'b00;

    pcie_rx #(
        .BAR_ADDR_W         (BAR_ADDR_W),
        .RAM_ADDR_W         (RAM_ADDR_W)
    ) UUT (
        .user_clk           (user_clk),
        .user_reset         (user_reset),
        .m_axis_rx_tdata_i  (rx_tdata),
        .m_axis_rx_tvalid_i (rx_tvalid),
        .m_axis_rx_tready_o (rx_tready),
        .compl_done_i       (compl_done),
        .dma_byte_len_i     (dma_byte_len),
        .bar_wr_o           (bar_wr),
        .req_o              (req),
        .req_compld_o       (req_compld),
        .ram_wr_o           (ram_wr),
        .ram_tx_start_o     (ram_tx_start),
        .ram_tx_end_o       (ram_tx_end)
    );

    initial begin
        user_clk = 1'b0;
        forever #(CLK_PERIOD / 2) user_clk = ~user_clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_bar_wr(input bar_wr_t got, input bar_wr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR bar_wr_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR req_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_ram_wr(input ram_wr_t got, input ram_wr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR ram_wr_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic void expected_from_tlp(input logic [31:0] dws[$]);
        tlp_dw0_t dw0;
        bar_wr_t  bw;
        mem_req_t rq;
        ram_wr_t  rw;
        int       n;
        int       dma_dw_len;
        logic     last;
        dw0        = tlp_dw0_t'(dws[0]);
        n          = dws.size();
        dma_dw_len = (int'(dma_byte_len) + 3) / 4;
        case (dw0.fmt_type)
            MEM_WR32, MEM_WR64: begin
                bw.en   = 1'b1;
                bw.be   = dws[1][7:0];
                bw.addr = BAR_ADDR_FIELD_W'(dws[n-2][BAR_ADDR_W-1:0]) & ~BAR_ADDR_FIELD_W'(3);
                bw.data = byte_swap(dws[n-1]);
                exp_bar_q.push_back(bw);
            end
            MEM_RD32, MEM_RD64: begin
                rq.tc   = dw0.tc;
                rq.td   = dw0.td;
                rq.ep   = dw0.ep;
                rq.attr = dw0.attr;
                rq.len  = dw0.len;
                rq.rid  = dws[1][31:16];
                rq.tag  = dws[1][15:8];
                rq.be   = dws[1][7:0];
                rq.addr = dws[n-1];
                exp_req_q.push_back(rq);
            end
            CPLD: begin
                // payload starts after three header dwords
                for (int i = 3; i < n; i++) begin
                    rw.we   = 1'b1;
                    rw.addr = RAM_ADDR_FIELD_W'(ref_ram_addr);
                    rw.data = byte_swap(dws[i]);
                    exp_ram_q.push_back(rw);
                    exp_first_q.push_back(ref_dw_total == 0);
                    ref_dw_total++;
                    ref_ram_addr++;
                    last = (i == n - 1) && (ref_dw_total >= dma_dw_len);
                    if (last) begin
                        ref_dw_total = 0;
                        ref_ram_addr = 0;
                    end
                    exp_last_q.push_back(last);
                end
            end
            default: ;
        endcase
    endfunction

    function automatic logic [31:0] make_dw0(input logic [6:0] fmt_type, input logic [9:0] len);
        tlp_dw0_t    h;
        logic [31:0] r;
        r          = $random(seed);
        h          = '0;
        h.fmt_type = fmt_type;
        h.tc       = r[2:0];
        h.td       = r[3];
        h.ep       = r[4];
        h.attr     = r[6:5];
        h.len      = len;
        return h;
    endfunction

    // tready is sampled mid-cycle, the beat is taken on the next rising edge
    task automatic send_beat(input logic [31:0] dw);
        logic taken;
        rx_tdata  <= dw;
        rx_tvalid <= 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge user_clk);
            taken = rx_tready;
            @(posedge user_clk);
        end
    endtask

    task automatic send_tlp();
        expected_from_tlp(tlp);
        foreach (tlp[i]) begin
            send_beat(tlp[i]);
        end
        rx_tvalid <= 1'b0;
    endtask

    task automatic do_mem_write(input logic is64);
        tlp.delete();
        tlp.push_back(make_dw0(is64 ? MEM_WR64 : MEM_WR32, 10'd1));
        tlp.push_back($random(seed));
        if (is64) begin
            tlp.push_back($random(seed));
        end
        tlp.push_back($random(seed));
        tlp.push_back($random(seed));
        send_tlp();
    endtask

    task automatic do_mem_read(input logic is64);
        int delay;
        tlp.delete();
        tlp.push_back(make_dw0(is64 ? MEM_RD64 : MEM_RD32, 10'({$random(seed)} % 64 + 1)));
        tlp.push_back($random(seed));
        if (is64) begin
            tlp.push_back($random(seed));
        end
        tlp.push_back($random(seed));
        send_tlp();
        delay = {$random(seed)} % 8;
        repeat (delay + 1) begin
            @(negedge user_clk);
            check_bit("m_axis_rx_tready_o", rx_tready, 1'b0);
            @(posedge user_clk);
        end
        compl_done <= 1'b1;
        @(posedge user_clk);
        compl_done <= 1'b0;
        @(negedge user_clk);
        check_bit("m_axis_rx_tready_o", rx_tready, 1'b1);
        @(posedge user_clk);
    endtask

    task automatic do_cpld(input int n_dw);
        tlp.delete();
        tlp.push_back(make_dw0(CPLD, 10'(n_dw)));
        tlp.push_back($random(seed));
        tlp.push_back($random(seed));
        repeat (n_dw) begin
            tlp.push_back($random(seed));
        end
        send_tlp();
    endtask

    task automatic wait_idle();
        while (exp_bar_q.size() != 0 || exp_req_q.size() != 0 || exp_ram_q.size() != 0
               || end_hist != 2'b00) begin
            @(posedge user_clk);
        end
    endtask

    // compares every strobe and the framing pulses each cycle
    always @(negedge user_clk) begin
        logic first_now;
        logic last_now;
        first_now = 1'b0;
        last_now  = 1'b0;
        if (!user_reset) begin
            if (bar_wr.en) begin
                if (exp_bar_q.size() == 0) abort_run("BAR write strobe with no write pending");
                else check_bar_wr(bar_wr, exp_bar_q.pop_front());
            end
            if (req_compld) begin
                if (exp_req_q.size() == 0) abort_run("read request with no read pending");
                else check_req(req, exp_req_q.pop_front());
            end
            if (ram_wr.we) begin
                if (exp_ram_q.size() == 0) begin
                    abort_run("RAM write with no completion payload pending");
                end else begin
                    first_now = exp_first_q.pop_front();
                    last_now  = exp_last_q.pop_front();
                    check_ram_wr(ram_wr, exp_ram_q.pop_front());
                end
            end
            check_bit("ram_tx_start_o", ram_tx_start, first_now | start_prev);
            check_bit("ram_tx_end_o", ram_tx_end, end_hist[0] | end_hist[1]);
            start_prev = first_now;
            end_hist   = {end_hist[0], last_now};
        end
    end

    initial begin
        #((BEATS_PER_TEST + 20) * N_TESTS * CLK_PERIOD);
        abort_run("run timed out before all tests completed");
    end

    initial begin
        seed         = 11;
        ref_ram_addr = 0;
        ref_dw_total = 0;
        user_reset   = 1'b1;
        rx_tdata     = '0;
        rx_tvalid    = 1'b0;
        compl_done   = 1'b0;
        dma_byte_len = RAM_ADDR_W'(32);
        repeat (3) @(posedge user_clk);
        user_reset <= 1'b0;
        @(posedge user_clk);
        @(negedge user_clk);
        check_bit("m_axis_rx_tready_o", rx_tready, 1'b1);
        check_bit("bar_wr_o.en", bar_wr.en, 1'b0);
        check_bit("req_compld_o", req_compld, 1'b0);
        check_bit("ram_wr_o.we", ram_wr.we, 1'b0);
        @(posedge user_clk);

        // unknown header is dropped, then plain writes
        tlp.delete();
        tlp.push_back(make_dw0(7'b10_00100, 10'd1));
        send_tlp();
        do_mem_write(1'b0);
        do_mem_write(1'b1);

        do_mem_read(1'b0);
        do_mem_write(1'b0);
        do_mem_read(1'b1);
        do_mem_write(1'b1);
        wait_idle();

        // one completion for the whole 8 dword transfer
        do_cpld(8);
        wait_idle();

        // 30 bytes round up to 8 dwords over three completions
        // the running total passes 7 on a last beat, which must not end the transfer
        dma_byte_len <= RAM_ADDR_W'(30);
        @(posedge user_clk);
        do_cpld(3);
        do_cpld(4);
        do_cpld(1);
        do_cpld(8);
        wait_idle();

        $display("TESTS PASSED");
        $finish;
    end

endmodule
